// File: femtoCore.f
source/corePkg.sv
source/decodeIf.sv
source/instrDecoder.sv
source/registerFile.sv
source/alu.sv
source/loadStoreUnit.sv
source/controlFsm.sv
source/femtoCore.sv
tests/testMemory.sv
tests/femtoCoreTb.sv

// File: tests/selfCheck.hex
// One 32-bit instruction or data word per line, in hex, from byte address 0
// The @ line moves to word 0x7C (byte 0x1F0), which holds the load data word
123450B7 // lui   x1, 0x12345
FF900113 // addi  x2, x0, -7
00500193 // addi  x3, x0, 5
00208233 // add   x4, x1, x2
18402023 // sw    x4, 0x180
40208233 // sub   x4, x1, x2
18402223 // sw    x4, 0x184
00312233 // slt   x4, x2, x3
18402423 // sw    x4, 0x188
00313233 // sltu  x4, x2, x3
18402623 // sw    x4, 0x18C
0020C233 // xor   x4, x1, x2
18402823 // sw    x4, 0x190
0020E233 // or    x4, x1, x2
18402A23 // sw    x4, 0x194
0020F233 // and   x4, x1, x2
18402C23 // sw    x4, 0x198
00311233 // sll   x4, x2, x3
18402E23 // sw    x4, 0x19C
00315233 // srl   x4, x2, x3
1A402023 // sw    x4, 0x1A0
40315233 // sra   x4, x2, x3
1A402223 // sw    x4, 0x1A4
00118013 // addi  x0, x3, 1
1A002423 // sw    x0, 0x1A8
00001297 // auipc x5, 1 at 0x64
1A502623 // sw    x5, 0x1AC
1A102823 // sw    x1, 0x1B0
0080036F // jal   x6, +8 at 0x70
1E002C23 // sw    x0, 0x1F8 skipped
1A602A23 // sw    x6, 0x1B4
084003E7 // jalr  x7, 0x84(x0) at 0x7C
1E002C23 // sw    x0, 0x1F8 skipped
1A702C23 // sw    x7, 0x1B8
08310863 // beq   x2, x3 not taken
00318463 // beq   x3, x3, +8
1E002C23 // sw    x0, 0x1F8 skipped
08319263 // bne   x3, x3 not taken
00311463 // bne   x2, x3, +8
1E002C23 // sw    x0, 0x1F8 skipped
0621CC63 // blt   x3, x2 not taken
00314463 // blt   x2, x3, +8
1E002C23 // sw    x0, 0x1F8 skipped
06315663 // bge   x2, x3 not taken
0021D463 // bge   x3, x2, +8
1E002C23 // sw    x0, 0x1F8 skipped
06316063 // bltu  x2, x3 not taken
0021E463 // bltu  x3, x2, +8
1E002C23 // sw    x0, 0x1F8 skipped
0421FA63 // bgeu  x3, x2 not taken
00317463 // bgeu  x2, x3, +8
1E002C23 // sw    x0, 0x1F8 skipped
1F000403 // lb    x8, 0x1F0
1A802E23 // sw    x8, 0x1BC
1F004403 // lbu   x8, 0x1F0
1C802023 // sw    x8, 0x1C0
1F201403 // lh    x8, 0x1F2
1C802223 // sw    x8, 0x1C4
1F205403 // lhu   x8, 0x1F2
1C802423 // sw    x8, 0x1C8
1F002403 // lw    x8, 0x1F0
1C802623 // sw    x8, 0x1CC
1C800823 // sb    x8, 0x1D0
1C8008A3 // sb    x8, 0x1D1
1C800923 // sb    x8, 0x1D2
1C8009A3 // sb    x8, 0x1D3
1C801A23 // sh    x8, 0x1D4
1C801B23 // sh    x8, 0x1D6
1E002E23 // sw    x0, 0x1FC done
0000006F // jal   x0, 0
1E002C23 // sw    x0, 0x1F8 wrong-path trap at 0x118
0000006F // jal   x0, 0
@7C
C3A57E84 // load data word

// File: tests/femtoCoreTb.sv
//**********************************************************
// RV32I core testbench
//**********************************************************
`timescale 1ns/1ps

module femtoCoreTb;
   import corePkg::*;

   localparam int          instrCount = 72;              // Instructions in the program
   localparam int          cycleLimit = 64 * instrCount;
   localparam int          sigTotal   = 26;              // Signature stores expected
   localparam logic [31:0] failAddr   = 32'h1F8;         // Wrong path marker
   localparam logic [31:0] doneAddr   = 32'h1FC;
   localparam logic [31:0] opA = 32'h1234_5000, opB = 32'hFFFF_FFF9, opC = 32'd5;
   localparam logic [31:0] loadWord = 32'hC3A5_7E84;     // Data word at 0x1F0
   localparam logic [31:0] auipcPc = 32'h64, jalPc = 32'h70, jalrPc = 32'h7C;

   logic        clk, reset;
   logic [31:0] memAddr, memWdata, memRdata, storeAddr, storeData, strobeAddr;
   logic [3:0]  memWmask, storeMask;
   logic        memRstrb, memRbusy, memWbusy, storeSeen;
   logic        strobeSeen = 1'b0, readPending = 1'b0, doneSeen = 1'b0;
   int          cycles = 0, sigCount = 0, valueErrors = 0, protocolErrors = 0;

   femtoCore uut (.clk, .reset, .memAddr, .memWdata, .memWmask, .memRdata,
                  .memRstrb, .memRbusy, .memWbusy);

   testMemory mem (.clk, .memAddr, .memWdata, .memWmask, .memRstrb, .memRdata,
                   .memRbusy, .memWbusy, .storeSeen, .storeAddr, .storeData, .storeMask);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic isSignature(logic [31:0] a);
      return a >= 32'h180 && a < 32'h1D8;
   endfunction

   // Expected words straight from the RV32I rules
   function automatic logic [31:0] expectedWord(logic [31:0] a);
      case (a)
         32'h180: return opA + opB;
         32'h184: return opA - opB;
         32'h188: return {31'b0, $signed(opB) < $signed(opC)};
         32'h18C: return {31'b0, opB < opC};
         32'h190: return opA ^ opB;
         32'h194: return opA | opB;
         32'h198: return opA & opB;
         32'h19C: return opB << opC[4:0];
         32'h1A0: return opB >> opC[4:0];
         32'h1A4: return $signed(opB) >>> opC[4:0];
         32'h1AC: return auipcPc + 32'h1000;
         32'h1B0: return opA;
         32'h1B4: return jalPc + 32'd4;   // Link words
         32'h1B8: return jalrPc + 32'd4;
         32'h1BC: return {{24{loadWord[7]}}, loadWord[7:0]};
         32'h1C0: return {24'b0, loadWord[7:0]};
         32'h1C4: return {{16{loadWord[31]}}, loadWord[31:16]};
         32'h1C8: return {16'b0, loadWord[31:16]};
         32'h1CC: return loadWord;
         32'h1D0, 32'h1D1, 32'h1D2, 32'h1D3: return {4{loadWord[7:0]}};
         32'h1D4, 32'h1D6: return {2{loadWord[15:0]}};
         default: return '0;  // Includes the x0 store
      endcase
   endfunction

   function automatic logic [3:0] expectedMask(logic [31:0] a);
      if (a >= 32'h1D0 && a < 32'h1D4)
         return 4'b0001 << a[1:0];  // One byte lane
      else if (a == 32'h1D4)
         return 4'b0011;
      else if (a == 32'h1D6)
         return 4'b1100;
      return 4'b1111;
   endfunction

   function automatic logic [31:0] laneBits(logic [3:0] m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   function automatic string sigName(logic [31:0] a);
      case (a)
         32'h180: return "add";
         32'h184: return "sub";
         32'h188: return "slt";
         32'h18C: return "sltu";
         32'h190: return "xor";
         32'h194: return "or";
         32'h198: return "and";
         32'h19C: return "sll";
         32'h1A0: return "srl";
         32'h1A4: return "sra";
         32'h1A8: return "x0";
         32'h1AC: return "auipc";
         32'h1B0: return "lui";
         32'h1B4: return "jal link";
         32'h1B8: return "jalr link";
         32'h1BC: return "lb";
         32'h1C0: return "lbu";
         32'h1C4: return "lh";
         32'h1C8: return "lhu";
         32'h1CC: return "lw";
         32'h1D4, 32'h1D6: return "sh";
         default: return "sb";
      endcase
   endfunction

   //**********************************************************
   // Bus tracking
   //**********************************************************
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (memRstrb) begin
         strobeSeen  <= 1'b1;
         readPending <= 1'b1;
         strobeAddr  <= memAddr;
      end else if (readPending && !memRbusy)
         readPending <= 1'b0;  // Data taken this cycle
      if (storeSeen && isSignature(storeAddr))
         sigCount <= sigCount + 1;
      if (storeSeen && storeAddr == doneAddr)
         doneSeen <= 1'b1;
   end

   //**********************************************************
   // Checks
   //**********************************************************
   assert property (@(posedge clk) storeSeen && isSignature(storeAddr) |->
      (storeData & laneBits(storeMask)) == (expectedWord(storeAddr) & laneBits(storeMask)))
      else begin
         valueErrors++;
         $display("ERROR %s expected %h actual %h", sigName($sampled(storeAddr)),
                  expectedWord($sampled(storeAddr)) & laneBits($sampled(storeMask)),
                  $sampled(storeData) & laneBits($sampled(storeMask)));
      end

   assert property (@(posedge clk) storeSeen && isSignature(storeAddr) |->
      storeMask == expectedMask(storeAddr))
      else begin
         valueErrors++;
         $display("ERROR %s mask expected %b actual %b", sigName($sampled(storeAddr)),
                  expectedMask($sampled(storeAddr)), $sampled(storeMask));
      end

   assert property (@(posedge clk) storeSeen |-> storeAddr != failAddr)
      else begin
         protocolErrors++;
         $display("Store to the fail address, a wrong-path instruction ran");
      end

   // X before the first clocked reset
   assert property (@(posedge clk) !reset && cycles > 0 |-> !memRstrb && memWmask == '0)
      else begin
         protocolErrors++;
         $display("Bus active while reset is held");
      end

   assert property (@(posedge clk) $rose(reset) |-> !memRstrb && memWmask == '0)
      else begin
         protocolErrors++;
         $display("Bus active in the first cycle after reset");
      end

   assert property (@(posedge clk) memRstrb && !strobeSeen |-> memAddr == resetAddr)
      else begin
         protocolErrors++;
         $display("First fetch did not use the reset address");
      end

   assert property (@(posedge clk) readPending |-> memAddr == strobeAddr)
      else begin
         protocolErrors++;
         $display("Address moved before the read data was taken");
      end

   assert property (@(posedge clk) memRstrb |-> !memWbusy)
      else begin
         protocolErrors++;
         $display("Read strobe while the memory was still busy writing");
      end

   initial begin
      reset = 1'b0;
      repeat (10) @(posedge clk);
      reset <= 1'b1;
      while (!doneSeen && cycles < cycleLimit)
         @(posedge clk);
      @(posedge clk);
      if (!doneSeen) begin
         protocolErrors++;
         $display("Timeout after %0d cycles without the done store", cycles);
      end
      if (sigCount != sigTotal) begin
         protocolErrors++;
         $display("Only %0d of %0d signature stores arrived", sigCount, sigTotal);
      end
      $display("Run ended after %0d cycles with %0d value errors and %0d protocol errors",
               cycles, valueErrors, protocolErrors);
      if (valueErrors == 0 && protocolErrors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// File: tests/testMemory.sv
//**********************************************************
// Test memory with busy levels
//**********************************************************
`timescale 1ns/1ps

module testMemory (
   input  logic        clk,
   input  logic [31:0] memAddr,
   input  logic [31:0] memWdata,
   input  logic [3:0]  memWmask,
   input  logic        memRstrb,
   output logic [31:0] memRdata,
   output logic        memRbusy,
   output logic        memWbusy,
   output logic        storeSeen,   // Store reported to the testbench
   output logic [31:0] storeAddr,
   output logic [31:0] storeData,
   output logic [3:0]  storeMask
);

   logic [31:0] words [0:127];  // 512 bytes, byte address bits 8..2
   logic [1:0]  wbusyLeft;      // Extra busy cycles after a store

   assign storeSeen = |memWmask;
   assign storeAddr = memAddr;
   assign storeData = memWdata;
   assign storeMask = memWmask;

   initial begin
      void'($urandom(12446));  // One seed for the whole run
      memRdata  = '0;
      memRbusy  = 1'b0;
      memWbusy  = 1'b0;
      wbusyLeft = '0;
      for (int i = 0; i < 128; i++)
         words[i] = {i[15:0] ^ 16'hA5A5, ~i[15:0]};  // Background fill
      $readmemh("tests/selfCheck.hex", words);
   end

   always @(posedge clk) begin
      memRdata <= words[memAddr[8:2]];  // Valid the cycle after the address
      for (int k = 0; k < 4; k++)
         if (memWmask[k])
            words[memAddr[8:2]][8*k +: 8] <= memWdata[8*k +: 8];
      // Read busy starts on a strobe, then clears at random
      if (memRstrb)
         memRbusy <= ($urandom % 2) == 0;
      else if (memRbusy)
         memRbusy <= ($urandom % 3) == 0;
      if (storeSeen) begin
         memWbusy  <= 1'b1;
         wbusyLeft <= 2'($urandom % 3);
      end else if (wbusyLeft != 0)
         wbusyLeft <= wbusyLeft - 2'd1;
      else
         memWbusy <= 1'b0;
   end

endmodule

// File: source/femtoCore.sv
//**********************************************************
// RV32I multi-cycle core top level
//**********************************************************
`timescale 1ns/1ps

module femtoCore (
   input  logic                     clk,
   input  logic                     reset,     // Active low
   output logic [corePkg::xlen-1:0] memAddr,
   output logic [corePkg::xlen-1:0] memWdata,
   output logic [3:0]               memWmask,
   input  logic [corePkg::xlen-1:0] memRdata,  // Instructions and data
   output logic                     memRstrb,
   input  logic                     memRbusy,
   input  logic                     memWbusy
);
   import corePkg::*;

   decodeIf dec ();

   logic [xlen-1:0] rs1Data, rs2Data, aluPlus, aluOut, loadData, writeBackData;
   logic            aluBusy, predicate, aluWr, instrLoad, writeBack;
   logic [3:0]      storeMask;

   instrDecoder decoder (.clk, .instrLoad, .memRdata, .dec(dec.producer));

   registerFile regs (.clk, .dec(dec.regSide), .writeBack, .writeBackData,
                      .rs1Data, .rs2Data);

   alu aluUnit (.clk, .dec(dec.aluSide), .rs1Data, .rs2Data, .aluWr, .aluPlus,
                .aluOut, .aluBusy, .predicate);

   loadStoreUnit lsu (.dec(dec.lsuSide), .memAddr, .memRdata, .rs2Data,
                      .loadData, .memWdata, .storeMask);

   controlFsm ctrl (.clk, .reset, .dec(dec.ctrlSide), .aluPlus, .aluOut, .aluBusy,
                    .predicate, .loadData, .storeMask, .memRbusy, .memWbusy,
                    .memAddr, .memRstrb, .memWmask, .instrLoad, .aluWr, .writeBack,
                    .writeBackData);

endmodule

// File: source/controlFsm.sv
//**********************************************************
// One-hot controller and program counter
//**********************************************************
`timescale 1ns/1ps

module controlFsm (
   input  logic                     clk,
   input  logic                     reset,
   decodeIf.ctrlSide                dec,
   input  logic [corePkg::xlen-1:0] aluPlus,
   input  logic [corePkg::xlen-1:0] aluOut,
   input  logic                     aluBusy,
   input  logic                     predicate,
   input  logic [corePkg::xlen-1:0] loadData,
   input  logic [3:0]               storeMask,
   input  logic                     memRbusy,
   input  logic                     memWbusy,
   output logic [corePkg::xlen-1:0] memAddr,
   output logic                     memRstrb,
   output logic [3:0]               memWmask,
   output logic                     instrLoad,
   output logic                     aluWr,
   output logic                     writeBack,
   output logic [corePkg::xlen-1:0] writeBackData
);
   import corePkg::*;

   logic [stateWidth-1:0] state;
   logic [xlen-1:0]       pc;
   logic [xlen-1:0]       pcPlus4, pcPlusImm;
   logic                  isAlu, jumpToImm;

   assign isAlu     = dec.isAluImm | dec.isAluReg;
   assign jumpToImm = dec.isJal | (dec.isBranch & predicate);
   assign pcPlus4   = pc + 32'd4;
   // JAL, AUIPC and branches share one adder
   assign pcPlusImm = pc + (dec.isJal ? dec.jImm : dec.isAuipc ? dec.uImm : dec.bImm);

   // Write-back sources are exclusive, so OR them
   assign writeBackData = (dec.isLui                ? dec.uImm  : '0) |
                          (isAlu                    ? aluOut    : '0) |
                          (dec.isAuipc              ? pcPlusImm : '0) |
                          ((dec.isJalr | dec.isJal) ? pcPlus4   : '0) |
                          (dec.isLoad               ? loadData  : '0);

   assign writeBack = ~(dec.isBranch | dec.isStore) &
                      (state[executeBit] | state[waitAluOrMemBit]);
   assign memRstrb  = state[fetchInstrBit] | state[loadBit];
   assign memWmask  = {4{state[storeBit]}} & storeMask;  // One cycle only
   assign instrLoad = state[waitInstrBit] & !memRbusy;
   assign aluWr     = state[executeBit] & isAlu;

   //**********************************************************
   // State, pc and address register
   //**********************************************************
   always_ff @(posedge clk) begin
      if (!reset) begin
         state                  <= '0;
         state[waitAluOrMemBit] <= 1'b1;  // Waits for the bus to go idle
         pc                     <= resetAddr;
      end else begin
         unique case (1'b1)
            state[executeBit]: begin
               pc      <= dec.isJalr ? aluPlus : jumpToImm ? pcPlusImm : pcPlus4;
               memAddr <= (dec.isJalr | dec.isStore | dec.isLoad) ? aluPlus :
                          jumpToImm ? pcPlusImm : pcPlus4;
               state                  <= '0;
               state[storeBit]        <= dec.isStore;
               state[waitAluOrMemBit] <= isAlu;
               state[loadBit]         <= dec.isLoad;
               state[fetchInstrBit]   <= !(dec.isStore | isAlu | dec.isLoad);
            end
            state[waitInstrBit]: begin
               if (!memRbusy) begin  // Word latched by decoder now
                  state               <= '0;
                  state[fetchRegsBit] <= 1'b1;
               end
            end
            state[waitAluOrMemBit]: begin
               if (!aluBusy && !memRbusy && !memWbusy) begin
                  memAddr              <= pc;
                  state                <= '0;
                  state[fetchInstrBit] <= 1'b1;
               end
            end
            default: begin  // Fixed one-step transitions
               state                  <= '0;
               state[waitAluOrMemBit] <= state[loadBit] | state[storeBit];
               state[executeBit]      <= state[fetchRegsBit];
               state[waitInstrBit]    <= state[fetchInstrBit];
            end
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!reset) $onehot(state))
      else $error("controller state not one-hot");

endmodule

// File: source/loadStoreUnit.sv
//**********************************************************
// Load and store lane alignment
//**********************************************************
`timescale 1ns/1ps

module loadStoreUnit (
   decodeIf.lsuSide                 dec,
   input  logic [corePkg::xlen-1:0] memAddr,
   input  logic [corePkg::xlen-1:0] memRdata,
   input  logic [corePkg::xlen-1:0] rs2Data,
   output logic [corePkg::xlen-1:0] loadData,
   output logic [corePkg::xlen-1:0] memWdata,
   output logic [3:0]               storeMask
);

   logic        byteAccess, halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   assign byteAccess = (dec.funct3[1:0] == 2'b00);
   assign halfAccess = (dec.funct3[1:0] == 2'b01);

   // Load lane pick from the low address bits
   assign loadHalf = memAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = memAddr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !dec.funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);  // LBU/LHU zero

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;

   //**********************************************************
   // Store data replicated into every lane
   //**********************************************************
   assign memWdata[7:0]   = rs2Data[7:0];
   assign memWdata[15:8]  = memAddr[0] ? rs2Data[7:0] : rs2Data[15:8];
   assign memWdata[23:16] = memAddr[1] ? rs2Data[7:0] : rs2Data[23:16];
   assign memWdata[31:24] = memAddr[0] ? rs2Data[7:0] :
                            memAddr[1] ? rs2Data[15:8] : rs2Data[31:24];

   // Byte lane, halfword pair or full word
   assign storeMask = byteAccess ? (4'b0001 << memAddr[1:0]) :
                      halfAccess ? (memAddr[1] ? 4'b1100 : 4'b0011) :
                                   4'b1111;

endmodule

// File: source/alu.sv
//**********************************************************
// ALU with serial shifter and branch compare
//**********************************************************
`timescale 1ns/1ps

module alu (
   input  logic                     clk,
   decodeIf.aluSide                 dec,
   input  logic [corePkg::xlen-1:0] rs1Data,
   input  logic [corePkg::xlen-1:0] rs2Data,
   input  logic                     aluWr,      // Start operation
   output logic [corePkg::xlen-1:0] aluPlus,    // Address and add path
   output logic [corePkg::xlen-1:0] aluOut,
   output logic                     aluBusy,
   output logic                     predicate
);
   import corePkg::*;

   logic [xlen-1:0] aluIn2;
   logic [xlen:0]   aluMinus;  // One subtract for SUB and every compare
   logic            lt, ltu, eq;
   logic [xlen-1:0] aluReg;
   logic [4:0]      aluShamt = '0;  // Shifter idle at power-up

   // Second operand is rs2, the store offset or the I immediate
   assign aluIn2 = (dec.isAluReg | dec.isBranch) ? rs2Data :
                   (dec.isStore ? dec.sImm : dec.iImm);

   assign aluPlus  = rs1Data + aluIn2;
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1Data} + 33'd1;
   assign ltu      = aluMinus[xlen];  // Borrow out
   assign lt       = (rs1Data[xlen-1] ^ aluIn2[xlen-1]) ? rs1Data[xlen-1] : aluMinus[xlen];
   assign eq       = (aluMinus[xlen-1:0] == '0);

   assign aluOut  = aluReg;
   assign aluBusy = |aluShamt;  // Shift still running

   //**********************************************************
   // Result register and shifter
   //**********************************************************
   always_ff @(posedge clk) begin
      if (aluWr) begin
         case (dec.funct3)
            3'b000:  aluReg <= dec.subFlag ? aluMinus[xlen-1:0] : aluPlus;  // ADD/SUB
            3'b010:  aluReg <= {{(xlen-1){1'b0}}, lt};   // SLT
            3'b011:  aluReg <= {{(xlen-1){1'b0}}, ltu};  // SLTU
            3'b100:  aluReg <= rs1Data ^ aluIn2;
            3'b110:  aluReg <= rs1Data | aluIn2;
            3'b111:  aluReg <= rs1Data & aluIn2;
            default: begin  // SLL, SRL, SRA load the shifter
               aluReg   <= rs1Data;
               aluShamt <= aluIn2[4:0];
            end
         endcase
      end else if (aluBusy) begin
         aluShamt <= aluShamt - 5'd1;  // One bit per cycle
         aluReg   <= dec.funct3[2] ? {dec.arithShift & aluReg[xlen-1], aluReg[xlen-1:1]}
                                   : aluReg << 1;
      end
   end

   // Branch condition from funct3
   always_comb begin
      case (dec.funct3)
         3'b000:  predicate = eq;    // BEQ
         3'b001:  predicate = !eq;   // BNE
         3'b100:  predicate = lt;    // BLT
         3'b101:  predicate = !lt;   // BGE
         3'b110:  predicate = ltu;   // BLTU
         3'b111:  predicate = !ltu;  // BGEU
         default: predicate = 1'b0;
      endcase
   end

   // Controller must wait out a running shift
   assert property (@(posedge clk) aluWr |-> !aluBusy)
      else $error("aluWr while shifter busy");

endmodule

// File: source/registerFile.sv
//**********************************************************
// Register file, two reads and one write
//**********************************************************
`timescale 1ns/1ps

module registerFile (
   input  logic                     clk,
   decodeIf.regSide                 dec,
   input  logic                     writeBack,
   input  logic [corePkg::xlen-1:0] writeBackData,
   output logic [corePkg::xlen-1:0] rs1Data,
   output logic [corePkg::xlen-1:0] rs2Data
);
   import corePkg::*;

   logic [xlen-1:0] regs [0:(1 << regAddrWidth)-1];
   logic            writeEn;

   assign writeEn = writeBack && (dec.rd != '0);  // x0 stays hard-wired

   always_ff @(posedge clk) begin
      rs1Data <= (dec.rs1 == '0) ? '0 : regs[dec.rs1];  // Valid one cycle later
      rs2Data <= (dec.rs2 == '0) ? '0 : regs[dec.rs2];
      if (writeEn)
         regs[dec.rd] <= writeBackData;
   end

endmodule

// File: source/instrDecoder.sv
//**********************************************************
// Instruction latch and decoder
//**********************************************************
`timescale 1ns/1ps

module instrDecoder (
   input  logic                     clk,
   input  logic                     instrLoad,  // Word valid on read bus
   input  logic [corePkg::xlen-1:0] memRdata,
   decodeIf.producer                dec
);
   import corePkg::*;

   instrWord_t instr;  // Held for the whole instruction

   always_ff @(posedge clk) begin
      if (instrLoad)
         instr <= memRdata;
   end

   // Class flags, one cycle behind the latch
   always_ff @(posedge clk) begin
      dec.isLoad   <= (instr.regs.opcode[6:2] == opLoad);
      dec.isAluImm <= (instr.regs.opcode[6:2] == opAluImm);
      dec.isAuipc  <= (instr.regs.opcode[6:2] == opAuipc);
      dec.isStore  <= (instr.regs.opcode[6:2] == opStore);
      dec.isAluReg <= (instr.regs.opcode[6:2] == opAluReg);
      dec.isLui    <= (instr.regs.opcode[6:2] == opLui);
      dec.isBranch <= (instr.regs.opcode[6:2] == opBranch);
      dec.isJalr   <= (instr.regs.opcode[6:2] == opJalr);
      dec.isJal    <= (instr.regs.opcode[6:2] == opJal);
   end

   // Register fields straight from the latched word
   assign dec.rs1        = instr.regs.rs1;
   assign dec.rs2        = instr.regs.rs2;
   assign dec.rd         = instr.regs.rd;
   assign dec.funct3     = instr.regs.funct3;
   assign dec.subFlag    = instr.regs.funct7[5] & instr.regs.opcode[5];  // ADDI uses bit 30
   assign dec.arithShift = instr.regs.funct7[5];

   // The five immediate formats
   assign dec.iImm = {{21{instr.imm.sign}}, instr.imm.hi6, instr.imm.mid4, instr.imm.bit20};
   assign dec.sImm = {{21{instr.imm.sign}}, instr.imm.hi6, instr.imm.low5};
   assign dec.uImm = {instr.imm.sign, instr.imm.hi6, instr.imm.mid4, instr.imm.bit20,
                      instr.imm.upper8, 12'b0};
   assign dec.bImm = {{20{instr.imm.sign}}, instr.imm.low5[0], instr.imm.hi6,
                      instr.imm.low5[4:1], 1'b0};
   assign dec.jImm = {{12{instr.imm.sign}}, instr.imm.upper8, instr.imm.bit20,
                      instr.imm.hi6, instr.imm.mid4, 1'b0};

endmodule

// File: source/decodeIf.sv
//**********************************************************
// Decoded instruction bundle
//**********************************************************
`timescale 1ns/1ps

interface decodeIf;
   import corePkg::*;

   logic isLoad, isAluImm, isAuipc, isStore, isAluReg;  // Class flags
   logic isLui, isBranch, isJalr, isJal;
   logic [regAddrWidth-1:0] rs1, rs2, rd;
   logic [2:0]              funct3;
   logic                    subFlag;     // SUB rather than ADD
   logic                    arithShift;  // SRA rather than SRL
   logic [xlen-1:0]         iImm, sImm, uImm, bImm, jImm;

   modport producer (output isLoad, isAluImm, isAuipc, isStore, isAluReg, isLui,
                     isBranch, isJalr, isJal, rs1, rs2, rd, funct3, subFlag,
                     arithShift, iImm, sImm, uImm, bImm, jImm);

   modport aluSide (input funct3, subFlag, arithShift, iImm, sImm, isAluReg,
                    isBranch, isStore);

   modport regSide (input rs1, rs2, rd);

   modport lsuSide (input funct3);

   // Controller sees every flag and the immediates it adds to the pc
   modport ctrlSide (input isLoad, isAluImm, isAuipc, isStore, isAluReg, isLui,
                     isBranch, isJalr, isJal, iImm, sImm, uImm, bImm, jImm, funct3);

endinterface

// File: source/corePkg.sv
//**********************************************************
// RV32I core shared definitions
//**********************************************************

package corePkg;

   localparam int xlen         = 32;  // Data and address width
   localparam int regAddrWidth = 5;   // x0 to x31
   localparam int stateWidth   = 7;   // One bit per controller state

   localparam logic [xlen-1:0] resetAddr = 32'h0000_0000;  // First fetch

   // Major opcodes, instruction bits 6 to 2
   localparam logic [4:0] opLoad   = 5'b00000;  // rd <- mem[rs1+iImm]
   localparam logic [4:0] opAluImm = 5'b00100;  // rd <- rs1 op iImm
   localparam logic [4:0] opAuipc  = 5'b00101;  // rd <- pc+uImm
   localparam logic [4:0] opStore  = 5'b01000;  // mem[rs1+sImm] <- rs2
   localparam logic [4:0] opAluReg = 5'b01100;  // rd <- rs1 op rs2
   localparam logic [4:0] opLui    = 5'b01101;  // rd <- uImm
   localparam logic [4:0] opBranch = 5'b11000;  // Conditional pc+bImm
   localparam logic [4:0] opJalr   = 5'b11001;  // rd <- pc+4, pc <- rs1+iImm
   localparam logic [4:0] opJal    = 5'b11011;  // rd <- pc+4, pc <- pc+jImm

   //**********************************************************
   // One-hot state bit positions
   //**********************************************************
   localparam int fetchInstrBit   = 0;  // Address out, read strobe
   localparam int waitInstrBit    = 1;  // Latch word when memory ready
   localparam int fetchRegsBit    = 2;  // Register reads in flight
   localparam int executeBit      = 3;  // Crossroads
   localparam int loadBit         = 4;  // Data read strobe
   localparam int waitAluOrMemBit = 5;  // Shifter or bus back-pressure
   localparam int storeBit        = 6;  // Write mask active

   // Register view of an instruction word
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } regView_t;

   // Raw bit groups the immediate formats are built from
   typedef struct packed {
      logic       sign;     // Bit 31
      logic [5:0] hi6;      // Bits 30..25
      logic [3:0] mid4;     // Bits 24..21
      logic       bit20;    // Bit 20
      logic [7:0] upper8;   // Bits 19..12
      logic [4:0] low5;     // Bits 11..7
      logic [6:0] opcode;
   } immView_t;

   typedef union packed {
      regView_t regs;
      immView_t imm;
   } instrWord_t;

endpackage
